/* common/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

    // ==============================
    // Cache geometry
    // ==============================

    localparam int NUM_WAYS    = 4;
    localparam int WAY_BITS    = 2;
    localparam int PLRU_BITS   = NUM_WAYS - 1;

    localparam int ADDR_BITS   = 32;
    localparam int OFFSET_BITS = 5;
    localparam int SET_BITS    = 4;
    localparam int NUM_SETS    = 1 << SET_BITS;
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS;

    // 32-byte lines
    localparam int LINE_BITS   = 8 << OFFSET_BITS;
    localparam int WORD_BITS   = 32;

    // Words handed to fetch per hit
    localparam int FETCH_WIDTH = 2;

    // ==============================
    // Address fields and state
    // ==============================

    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [SET_BITS-1:0]    set_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

    typedef logic [WAY_BITS-1:0]    way_t;

    // Tree bits for one set
    typedef logic [PLRU_BITS-1:0]   plru_t;

    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [WORD_BITS-1:0]   word_t;

endpackage

`default_nettype wire

/* common/icache_bus_pkg.sv */
`default_nettype none

package icache_bus_pkg;

    // ==============================
    // Fetch port
    // ==============================

    typedef struct packed {
        logic                  read;
        icache_cfg_pkg::addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic                                                   resp;
        icache_cfg_pkg::word_t [icache_cfg_pkg::FETCH_WIDTH-1:0] rdata;
    } fetch_resp_t;

    // ==============================
    // Memory port
    // ==============================

    // Line-aligned read request
    typedef struct packed {
        logic                  read;
        icache_cfg_pkg::addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic                  ready;
        logic                  rvalid;
        icache_cfg_pkg::addr_t raddr;
        icache_cfg_pkg::line_t rdata;
    } mem_resp_t;

    // Request held between fetch and process
    typedef struct packed {
        logic                    read;
        icache_cfg_pkg::offset_t offset;
        icache_cfg_pkg::set_t    set;
        icache_cfg_pkg::tag_t    tag;
    } stage_reg_t;

endpackage

`default_nettype wire

/* design/sram_1rw.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_1rw #(
    parameter int WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 cs,
    input  logic                 we,
    input  icache_cfg_pkg::set_t addr,
    input  logic [WIDTH-1:0]     din,
    output logic [WIDTH-1:0]     dout
);

    logic [WIDTH-1:0] mem [icache_cfg_pkg::NUM_SETS];

    // One access per cycle, dout holds between reads
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* design/state_array.sv */
`timescale 1ns/1ps
`default_nettype none

module state_array #(
    parameter int WIDTH = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_en,
    input  icache_cfg_pkg::set_t rd_addr,
    output logic [WIDTH-1:0]     rd_data,
    input  logic                 wr_en,
    input  icache_cfg_pkg::set_t wr_addr,
    input  logic [WIDTH-1:0]     wr_data
);

    logic [WIDTH-1:0] entries [icache_cfg_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < icache_cfg_pkg::NUM_SETS; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // Same-set write in the read cycle wins
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            if (wr_en && (wr_addr == rd_addr)) begin
                rd_data <= wr_data;
            end else begin
                rd_data <= entries[rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* icache/plru_update.sv */
`timescale 1ns/1ps
`default_nettype none

module plru_update (
    input  icache_cfg_pkg::plru_t cur_plru,
    input  icache_cfg_pkg::way_t  hit_way,
    output icache_cfg_pkg::way_t  victim_way,
    output icache_cfg_pkg::plru_t next_plru
);

    // ==============================
    // Tree layout
    // ==============================
    // Bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    // A clear bit sends the victim search to the lower side

    always_comb begin
        victim_way[1] = cur_plru[0];
        victim_way[0] = cur_plru[0] ? cur_plru[2] : cur_plru[1];
    end

    // Point the accessed path away from the used way
    always_comb begin
        next_plru    = cur_plru;
        next_plru[0] = !hit_way[1];
        if (hit_way[1]) begin
            next_plru[2] = !hit_way[0];
        end else begin
            next_plru[1] = !hit_way[0];
        end
    end

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                kill,
    input  icache_bus_pkg::stage_reg_t                          stage,
    input  icache_cfg_pkg::tag_t [icache_cfg_pkg::NUM_WAYS-1:0] tag_out,
    input  logic [icache_cfg_pkg::NUM_WAYS-1:0]                 valid_out,
    input  icache_bus_pkg::mem_resp_t                           mem_resp,
    output icache_bus_pkg::mem_req_t                            mem_req,
    output logic                                                stall,
    output logic                                                fill_write,
    output logic                                                reread,
    output icache_cfg_pkg::way_t                                hit_way
);

    typedef enum logic [2:0] {
        LOOKUP,
        FILL_REQ,
        FILL_WAIT,
        WRITE,
        REREAD,
        DRAIN
    } state_t;

    state_t                              state;
    state_t                              state_next;
    logic [icache_cfg_pkg::NUM_WAYS-1:0] way_match;
    logic                                hit;
    logic                                drop;
    logic                                line_back;
    icache_cfg_pkg::addr_t               miss_addr;

    // ==============================
    // Tag compare
    // ==============================

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < icache_cfg_pkg::NUM_WAYS; i++) begin
            way_match[i] = valid_out[i] && (tag_out[i] == stage.tag);
            if (way_match[i]) begin
                hit_way = icache_cfg_pkg::way_t'(i);
            end
        end
    end

    assign hit = |way_match;

    // ==============================
    // Miss sequencing
    // ==============================

    assign line_back = mem_resp.rvalid && (mem_resp.raddr == miss_addr);

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (stage.read && !hit && !kill) begin
                    state_next = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_resp.ready) begin
                    state_next = (drop || kill) ? DRAIN : FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (line_back) begin
                    state_next = kill ? LOOKUP : WRITE;
                end else if (kill) begin
                    state_next = DRAIN;
                end
            end
            WRITE:  state_next = REREAD;
            REREAD: state_next = LOOKUP;
            DRAIN: begin
                if (line_back) begin
                    state_next = LOOKUP;
                end
            end
            default: state_next = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
            drop  <= 1'b0;
        end else begin
            state <= state_next;
            // Kill seen before memory took the request
            drop  <= (state == FILL_REQ) && !mem_resp.ready && (drop || kill);
        end
    end

    // Held for the whole refill, the stage may move on after a kill
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            miss_addr <= {stage.tag, stage.set, {icache_cfg_pkg::OFFSET_BITS{1'b0}}};
        end
    end

    assign mem_req.read = (state == FILL_REQ);
    assign mem_req.addr = miss_addr;

    assign stall      = (state != LOOKUP) || (stage.read && !hit);
    assign fill_write = (state == WRITE);
    assign reread     = (state == REREAD);

endmodule

`default_nettype wire

/* icache/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        kill,
    input  icache_bus_pkg::fetch_req_t  fetch_req,
    output icache_bus_pkg::fetch_resp_t fetch_resp,
    output icache_bus_pkg::mem_req_t    mem_req,
    input  icache_bus_pkg::mem_resp_t   mem_resp
);

    icache_bus_pkg::stage_reg_t                                stage;
    icache_bus_pkg::stage_reg_t                                stage_next;

    logic                                                      load;
    logic                                                      accept;
    logic                                                      arr_rd;
    icache_cfg_pkg::set_t                                      arr_set;

    logic                                                      stall;
    logic                                                      fill_write;
    logic                                                      reread;
    logic                                                      resp;
    logic [icache_cfg_pkg::NUM_WAYS-1:0]                       way_fill;

    icache_cfg_pkg::way_t                                      hit_way;
    icache_cfg_pkg::way_t                                      victim_way;
    icache_cfg_pkg::plru_t                                     cur_plru;
    icache_cfg_pkg::plru_t                                     next_plru;

    icache_cfg_pkg::tag_t [icache_cfg_pkg::NUM_WAYS-1:0]       tag_out;
    logic [icache_cfg_pkg::NUM_WAYS-1:0]                       valid_out;
    icache_cfg_pkg::line_t                                     data_out [icache_cfg_pkg::NUM_WAYS];
    icache_cfg_pkg::line_t                                     hit_line;
    icache_cfg_pkg::line_t                                     fill_line;

    // ==============================
    // Fetch stage
    // ==============================

    assign stage_next = '{
        read:   fetch_req.read,
        offset: fetch_req.addr[icache_cfg_pkg::OFFSET_BITS-1:0],
        set:    fetch_req.addr[icache_cfg_pkg::OFFSET_BITS +: icache_cfg_pkg::SET_BITS],
        tag:    fetch_req.addr[icache_cfg_pkg::ADDR_BITS-1 -: icache_cfg_pkg::TAG_BITS]
    };

    assign load = !stall || kill;

    // A fill owns the single array port for its cycle
    assign accept  = load && !fill_write;
    assign arr_rd  = accept || reread;
    assign arr_set = accept ? stage_next.set : stage.set;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.read <= 1'b0;
        end else if (load) begin
            stage <= stage_next;
        end
    end

    // Refill line lands here, written one cycle later
    always_ff @(posedge clk) begin
        if (mem_resp.rvalid) begin
            fill_line <= mem_resp.rdata;
        end
    end

    for (genvar w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin : g_way
        assign way_fill[w] = fill_write && (victim_way == icache_cfg_pkg::way_t'(w));

        sram_1rw #(
            .WIDTH (icache_cfg_pkg::LINE_BITS)
        ) i_data (
            .clk  (clk),
            .cs   (arr_rd || way_fill[w]),
            .we   (way_fill[w]),
            .addr (arr_set),
            .din  (fill_line),
            .dout (data_out[w])
        );

        sram_1rw #(
            .WIDTH (icache_cfg_pkg::TAG_BITS)
        ) i_tag (
            .clk  (clk),
            .cs   (arr_rd || way_fill[w]),
            .we   (way_fill[w]),
            .addr (arr_set),
            .din  (stage.tag),
            .dout (tag_out[w])
        );

        state_array #(
            .WIDTH (1)
        ) i_valid (
            .clk     (clk),
            .rst     (rst),
            .rd_en   (arr_rd),
            .rd_addr (arr_set),
            .rd_data (valid_out[w]),
            .wr_en   (way_fill[w]),
            .wr_addr (stage.set),
            .wr_data (1'b1)
        );
    end

    state_array #(
        .WIDTH (icache_cfg_pkg::PLRU_BITS)
    ) i_plru (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (arr_rd),
        .rd_addr (arr_set),
        .rd_data (cur_plru),
        .wr_en   (resp),
        .wr_addr (stage.set),
        .wr_data (next_plru)
    );

    // ==============================
    // Process stage
    // ==============================

    icache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill),
        .stage      (stage),
        .tag_out    (tag_out),
        .valid_out  (valid_out),
        .mem_resp   (mem_resp),
        .mem_req    (mem_req),
        .stall      (stall),
        .fill_write (fill_write),
        .reread     (reread),
        .hit_way    (hit_way)
    );

    plru_update i_plru_update (
        .cur_plru   (cur_plru),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .next_plru  (next_plru)
    );

    // Killed request gets no response
    assign resp = stage.read && !stall && !kill;
    assign fetch_resp.resp = resp;

    assign hit_line = data_out[hit_way];

    // Offset is word aligned and keeps both words in the line
    always_comb begin
        for (int i = 0; i < icache_cfg_pkg::FETCH_WIDTH; i++) begin
            fetch_resp.rdata[i] = hit_line[
                (int'(stage.offset[icache_cfg_pkg::OFFSET_BITS-1:2]) + i)
                * icache_cfg_pkg::WORD_BITS +: icache_cfg_pkg::WORD_BITS];
        end
    end

endmodule

`default_nettype wire

/* sim/icache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        stall,
    input icache_bus_pkg::fetch_resp_t fetch_resp,
    input icache_bus_pkg::mem_req_t    mem_req,
    input icache_bus_pkg::mem_resp_t   mem_resp
);

    logic refill_pending;

    // Line taken by memory and not yet returned
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_pending <= 1'b0;
        end else if (mem_req.read && mem_resp.ready) begin
            refill_pending <= 1'b1;
        end else if (mem_resp.rvalid) begin
            refill_pending <= 1'b0;
        end
    end

    // Request held until memory takes it
    assert property (@(posedge clk) disable iff (rst)
        mem_req.read && !mem_resp.ready |=> mem_req.read && $stable(mem_req.addr))
        else $error("memory read dropped or changed before ready");

    // Fetch side stalled with no resp while a refill is in flight
    assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || refill_pending) |-> stall && !fetch_resp.resp)
        else $error("fetch resp or missing stall while a refill is in flight");

    assert property (@(posedge clk)
        rst |=> !fetch_resp.resp && !mem_req.read)
        else $error("resp or memory read active in reset");

endmodule

bind icache icache_asserts i_icache_asserts (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .fetch_resp (fetch_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp)
);

`default_nettype wire

/* sim/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int OFS = icache_cfg_pkg::OFFSET_BITS;
    localparam int SETB = icache_cfg_pkg::SET_BITS;
    localparam int NUM_REQS = 80;
    // Accept, lookup, ready wait, answer, write, reread and some margin
    localparam int MISS_CYCLES = 24;
    localparam int LIMIT_CYCLES = 8 + NUM_REQS * MISS_CYCLES;

    logic                        clk;
    logic                        rst;
    logic                        kill;
    icache_bus_pkg::fetch_req_t  fetch_req;
    icache_bus_pkg::fetch_resp_t fetch_resp;
    icache_bus_pkg::mem_req_t    mem_req;
    icache_bus_pkg::mem_resp_t   mem_resp;

    // Reference state of the cache
    icache_cfg_pkg::tag_t  m_tag   [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];
    bit                    m_valid [icache_cfg_pkg::NUM_SETS][icache_cfg_pkg::NUM_WAYS];
    icache_cfg_pkg::plru_t m_plru  [icache_cfg_pkg::NUM_SETS];

    logic [63:0] exp_resp [$];
    logic [31:0] exp_mem [$];

    icache i_icache (
        .clk        (clk),
        .rst        (rst),
        .kill       (kill),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Reference functions
    // ==============================

    function automatic icache_cfg_pkg::word_t mem_word(input icache_cfg_pkg::addr_t a);
        return (a >> 2) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [63:0] expected_words(input icache_cfg_pkg::addr_t a);
        return {mem_word(a + 32'd4), mem_word(a)};
    endfunction

    function automatic icache_cfg_pkg::line_t make_line(input icache_cfg_pkg::addr_t a);
        icache_cfg_pkg::line_t line;
        for (int j = 0; j < 8; j++) begin
            line[j*32 +: 32] = mem_word(a + 32'(4 * j));
        end
        return line;
    endfunction

    function automatic icache_cfg_pkg::addr_t mk(input int tag, input int set, input int off);
        return icache_cfg_pkg::addr_t'((tag << (OFS + SETB)) | (set << OFS) | off);
    endfunction

    // Tree node 0 chooses the half and nodes 1 and 2 the way inside it
    function automatic icache_cfg_pkg::way_t pick_victim(input icache_cfg_pkg::plru_t p);
        logic upper;
        upper = p[0];
        return {upper, upper ? p[2] : p[1]};
    endfunction

    function automatic icache_cfg_pkg::plru_t touch(input icache_cfg_pkg::plru_t p,
                                                    input icache_cfg_pkg::way_t w);
        icache_cfg_pkg::plru_t n;
        n = p;
        n[0] = ~w[1];
        n[1 + int'(w[1])] = ~w[0];
        return n;
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            abort($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    always @(negedge clk) begin
        if (!rst && mem_req.read && mem_resp.ready) begin
            if (exp_mem.size() == 0) begin
                abort($sformatf("Fail at %0d ns: memory read of %h on a hit", $time, mem_req.addr));
            end else begin
                check_value(64'(mem_req.addr), 64'(exp_mem.pop_front()), "memory line address");
            end
        end
        if (!rst && fetch_resp.resp) begin
            if (exp_resp.size() == 0) begin
                abort($sformatf("Fail at %0d ns: response without a request", $time));
            end else begin
                check_value(fetch_resp.rdata, exp_resp.pop_front(), "fetch words");
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        abort("The run hung: the watchdog limit was reached before all requests finished");
    end

    // ==============================
    // Memory model
    // ==============================

    initial begin
        icache_cfg_pkg::addr_t line_addr;
        int unsigned gap;
        mem_resp <= '0;
        forever begin
            @(negedge clk);
            if (mem_req.read) begin
                line_addr = mem_req.addr;
                gap = $urandom % 4;
                repeat (gap + 1) @(posedge clk);
                mem_resp.ready <= 1'b1;
                @(posedge clk);
                mem_resp.ready <= 1'b0;
                gap = 2 + $urandom % 5;
                repeat (gap) @(posedge clk);
                mem_resp.rvalid <= 1'b1;
                mem_resp.raddr  <= line_addr;
                mem_resp.rdata  <= make_line(line_addr);
                @(posedge clk);
                mem_resp.rvalid <= 1'b0;
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    task automatic predict(input icache_cfg_pkg::addr_t a, output bit hit);
        int s;
        icache_cfg_pkg::way_t w;
        s = int'(a[OFS +: SETB]);
        hit = 1'b0;
        w = '0;
        for (int i = 0; i < icache_cfg_pkg::NUM_WAYS; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == a[31 -: icache_cfg_pkg::TAG_BITS]) begin
                hit = 1'b1;
                w = icache_cfg_pkg::way_t'(i);
            end
        end
        if (!hit) begin
            w = pick_victim(m_plru[s]);
            m_valid[s][w] = 1'b1;
            m_tag[s][w] = a[31 -: icache_cfg_pkg::TAG_BITS];
            exp_mem.push_back({a[31:OFS], {OFS{1'b0}}});
        end
        m_plru[s] = touch(m_plru[s], w);
        exp_resp.push_back(expected_words(a));
    endtask

    task automatic do_fetch(input icache_cfg_pkg::addr_t a);
        bit hit;
        predict(a, hit);
        @(posedge clk);
        fetch_req <= '{read: 1'b1, addr: a};
        @(posedge clk);
        fetch_req.read <= 1'b0;
        @(negedge clk);
        if (hit) begin
            check_value(64'(fetch_resp.resp), 64'd1, "resp one cycle after a hit");
        end
        while (!fetch_resp.resp) @(negedge clk);
    endtask

    // Predicted hits at one request per cycle
    task automatic hit_burst(input icache_cfg_pkg::addr_t list [$]);
        bit hit;
        foreach (list[i]) begin
            predict(list[i], hit);
            check_value(64'(hit), 64'd1, "burst member predicted as hit");
            @(posedge clk);
            fetch_req <= '{read: 1'b1, addr: list[i]};
            if (i > 0) begin
                @(negedge clk);
                check_value(64'(fetch_resp.resp), 64'd1, "back-to-back resp");
            end
        end
        @(posedge clk);
        fetch_req.read <= 1'b0;
        @(negedge clk);
        check_value(64'(fetch_resp.resp), 64'd1, "back-to-back resp");
    endtask

    // The miss on a is killed while memory owes its line and c rides in with kill
    task automatic kill_miss(input icache_cfg_pkg::addr_t a, input icache_cfg_pkg::addr_t c);
        bit hit;
        exp_mem.push_back({a[31:OFS], {OFS{1'b0}}});
        @(posedge clk);
        fetch_req <= '{read: 1'b1, addr: a};
        @(posedge clk);
        fetch_req.read <= 1'b0;
        do @(negedge clk); while (!(mem_req.read && mem_resp.ready));
        predict(c, hit);
        @(posedge clk);
        kill <= 1'b1;
        fetch_req <= '{read: 1'b1, addr: c};
        @(posedge clk);
        kill <= 1'b0;
        fetch_req.read <= 1'b0;
        do @(negedge clk); while (!fetch_resp.resp);
    endtask

    initial begin
        icache_cfg_pkg::addr_t burst [$];
        void'($urandom(94));
        // PLRU bits are clear after reset
        foreach (m_plru[s]) begin
            m_plru[s] = '0;
        end
        rst <= 1'b1;
        kill <= 1'b0;
        fetch_req <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Cold misses
        do_fetch(mk(1, 0, 0));
        do_fetch(mk(2, 1, 8));
        do_fetch(mk(3, 2, 24));
        do_fetch(mk(4, 5, 12));

        burst = '{mk(1, 0, 4), mk(2, 1, 0), mk(3, 2, 16), mk(4, 5, 24), mk(1, 0, 20),
                  mk(2, 1, 12)};
        hit_burst(burst);

        // Five tags fighting over set 3
        for (int t = 16; t < 20; t++) begin
            do_fetch(mk(t, 3, 0));
        end
        do_fetch(mk(16, 3, 8));
        do_fetch(mk(18, 3, 4));
        do_fetch(mk(20, 3, 16));
        for (int t = 16; t < 21; t++) begin
            do_fetch(mk(t, 3, 24));
        end

        kill_miss(mk(32, 7, 0), mk(1, 0, 8));
        do_fetch(mk(32, 7, 4));
        kill_miss(mk(33, 8, 4), mk(34, 9, 0));

        for (int n = 0; n < 40; n++) begin
            do_fetch(mk(64 + int'($urandom % 6), int'($urandom % 2), int'($urandom % 7) * 4));
        end

        repeat (10) @(posedge clk);
        if (exp_resp.size() == 0 && exp_mem.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort("Responses or memory requests that were expected never came");
        end
    end

endmodule

`default_nettype wire

/* list.f */
common/icache_cfg_pkg.sv
common/icache_bus_pkg.sv
design/sram_1rw.sv
design/state_array.sv
icache/plru_update.sv
icache/icache_ctrl.sv
icache/icache.sv
sim/icache_asserts.sv
sim/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_icache -f list.f -o sim_icache &&
./obj_dir/sim_icache || { echo "simulation failed"; exit 1; }
